// ==== src/jtag_bridge_params.svh ====
`ifndef JTAG_BRIDGE_PARAMS_SVH
`define JTAG_BRIDGE_PARAMS_SVH

`define JB_OFFSET_ADDR 32'h1000_0000 // word address of the status register
`define JB_DATA_W      32
`define JB_ID_W        4
`define JB_LEN_W       8
`define JB_FIFO_AW     4             // 16 entries per FIFO
`define JB_OP_W        4
`define JB_CYCLE_W     28

// command op codes, anything else is dropped
`define JB_OP_TMS      4'd1
`define JB_OP_IDLE     4'd2
`define JB_OP_SHIFT    4'd3

`endif

// ==== src/jtag_bridge_pkg.sv ====
`default_nettype none
`include "jtag_bridge_params.svh"

package jtag_bridge_pkg;

    typedef struct packed {
        logic [`JB_ID_W-1:0]  id;
        logic [31:0]          addr;
        logic [`JB_LEN_W-1:0] len;   // beats minus one
        logic [1:0]           burst; // 0 fixed, 1 incr
    } bus_addr_t;

    typedef struct packed {
        logic [`JB_DATA_W-1:0]   data;
        logic [`JB_DATA_W/8-1:0] strb;
        logic                    last;
    } bus_wdata_t;

    typedef struct packed {
        logic [`JB_ID_W-1:0] id;
        logic [1:0]          resp;
    } bus_bresp_t;

    typedef struct packed {
        logic [`JB_ID_W-1:0]   id;
        logic [`JB_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } bus_rdata_t;

    typedef struct packed {
        logic [6:0] rsvd_31_25;
        logic       cmd_done;
        logic [4:0] rsvd_23_19;
        logic       cmd_full;
        logic       cmd_empty;
        logic       cmd_clear;
        logic [4:0] rsvd_15_11;
        logic       in_full;
        logic       in_empty;
        logic       in_clear;
        logic [4:0] rsvd_7_3;
        logic       out_full;
        logic       out_empty;
        logic       out_clear;
    } status_fields_t;

    typedef union packed {
        logic [31:0]    raw;
        status_fields_t f;
    } status_word_u;

    typedef struct packed {
        logic [`JB_OP_W-1:0]    op;
        logic [`JB_CYCLE_W-1:0] cycles; // tck pulses to run
    } cmd_fields_t;

    typedef union packed {
        logic [31:0] raw;
        cmd_fields_t f;
    } cmd_word_u;

endpackage

`default_nettype wire

// ==== src/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "jtag_bridge_params.svh"

module sync_fifo #(
    parameter int WIDTH = `JB_DATA_W
) (
    input  wire              clk,
    input  wire              jtag_rstn_sync,
    input  wire              clear,
    input  wire              push,
    input  wire [WIDTH-1:0]  push_data,
    input  wire              pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);
    localparam int DEPTH = 1 << `JB_FIFO_AW;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [`JB_FIFO_AW-1:0] wr_ptr, rd_ptr;
    logic [`JB_FIFO_AW:0]   count;
    logic                  do_push, do_pop;

    assign do_push = push && !full && !clear;
    assign do_pop  = pop && !empty && !clear;
    assign empty   = count == '0;
    assign full    = count == (`JB_FIFO_AW+1)'(DEPTH);
    assign head    = mem[rd_ptr]; // show-ahead

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    no_overflow_a: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        push |-> !full);
    no_underflow_a: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== src/tap_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "jtag_bridge_params.svh"

module tap_shifter (
    input  wire                             clk,
    input  wire                             jtag_rstn_sync,
    input  wire jtag_bridge_pkg::cmd_word_u cmd_head,
    input  wire                             cmd_empty,
    input  wire [`JB_DATA_W-1:0]            in_head,
    input  wire                             in_empty,
    input  wire                             out_full,
    input  wire                             tdo,
    output logic                            cmd_pop,
    output logic                            in_pop,
    output logic                            out_push,
    output logic [`JB_DATA_W-1:0]           out_data,
    output logic                            busy,
    output logic                            tck,
    output logic                            tms,
    output logic                            tdi
);
    localparam int IW = $clog2(`JB_DATA_W);

    logic [`JB_OP_W-1:0]    op;
    logic [`JB_CYCLE_W-1:0] remaining;  // pulses still to run
    logic [`JB_DATA_W-1:0]  in_word;
    logic [IW-1:0]          in_idx;
    logic                   have_word;
    logic [IW:0]            cap_cnt;    // bits captured into out_data
    logic                   pend_push;
    logic                   is_shift, need_word, stall, op_ok, last_pulse, run_low;

    assign is_shift   = op == `JB_OP_SHIFT;
    assign need_word  = is_shift && !have_word;
    assign stall      = (pend_push && out_full) || (need_word && in_empty);
    assign op_ok      = cmd_head.f.op == `JB_OP_TMS || cmd_head.f.op == `JB_OP_IDLE ||
                        cmd_head.f.op == `JB_OP_SHIFT;
    assign last_pulse = remaining == `JB_CYCLE_W'(1);
    assign run_low    = busy && !tck;

    assign cmd_pop  = !busy && !cmd_empty;
    assign in_pop   = run_low && remaining != '0 && !stall && need_word;
    assign out_push = run_low && pend_push && !out_full;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            busy      <= 1'b0;
            op        <= '0;
            remaining <= '0;
            tck       <= 1'b0;
            tms       <= 1'b0;
            tdi       <= 1'b0;
            in_idx    <= '0;
            have_word <= 1'b0;
            cap_cnt   <= '0;
            pend_push <= 1'b0;
            out_data  <= '0;
        end else if (!busy) begin
            if (cmd_pop) begin
                op        <= cmd_head.f.op;
                remaining <= cmd_head.f.cycles;
                busy      <= op_ok && cmd_head.f.cycles != '0; // bad op or zero is dropped
            end
        end else if (!tck) begin
            if (out_push) begin
                pend_push <= 1'b0;
                cap_cnt   <= '0;
                out_data  <= '0; // zero fill for a partial word
            end
            if (remaining == '0) begin
                busy <= pend_push && out_full; // wait for the last push
            end else if (!stall) begin
                tck <= 1'b1;
                tms <= op == `JB_OP_TMS;
                tdi <= is_shift && (have_word ? in_word[in_idx] : in_head[0]);
                if (need_word) have_word <= 1'b1;
            end
        end else begin
            tck       <= 1'b0;
            remaining <= remaining - 1'b1;
            if (is_shift) begin
                out_data[cap_cnt[IW-1:0]] <= tdo; // sampled at end of tck high
                cap_cnt <= cap_cnt + 1'b1;
                in_idx  <= in_idx + 1'b1;
                if (in_idx == IW'(`JB_DATA_W - 1) || last_pulse) begin
                    have_word <= 1'b0;
                    in_idx    <= '0;
                end
                if (cap_cnt == (IW+1)'(`JB_DATA_W - 1) || last_pulse) pend_push <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_pop) in_word <= in_head;
    end

    pins_stable_a: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        tck |=> $stable({tms, tdi}));

endmodule

`default_nettype wire

// ==== src/jtag_bus_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "jtag_bridge_params.svh"

module jtag_bus_ctrl (
    input  wire                              clk,
    input  wire                              jtag_rstn_sync,
    input  wire jtag_bridge_pkg::bus_addr_t  aw,
    input  wire                              aw_valid,
    output logic                             aw_ready,
    input  wire jtag_bridge_pkg::bus_wdata_t w,
    input  wire                              w_valid,
    output logic                             w_ready,
    output jtag_bridge_pkg::bus_bresp_t      b,
    output logic                             b_valid,
    input  wire                              b_ready,
    input  wire jtag_bridge_pkg::bus_addr_t  ar,
    input  wire                              ar_valid,
    output logic                             ar_ready,
    output jtag_bridge_pkg::bus_rdata_t      r,
    output logic                             r_valid,
    input  wire                              r_ready,
    input  wire                              in_full,
    input  wire                              in_empty,
    input  wire                              cmd_full,
    input  wire                              cmd_empty,
    input  wire                              out_full,
    input  wire                              out_empty,
    input  wire [`JB_DATA_W-1:0]             out_head,
    input  wire                              shifter_busy,
    output logic                             in_push,
    output logic                             cmd_push,
    output logic [`JB_DATA_W-1:0]            push_data,
    output logic                             out_pop,
    output logic                             in_clear,
    output logic                             cmd_clear,
    output logic                             out_clear
);
    localparam logic [31:0] STAT_ADDR = `JB_OFFSET_ADDR;
    localparam logic [31:0] OUT_ADDR  = `JB_OFFSET_ADDR + 32'd1;
    localparam logic [31:0] IN_ADDR   = `JB_OFFSET_ADDR + 32'd2;
    localparam logic [31:0] CMD_ADDR  = `JB_OFFSET_ADDR + 32'd3;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    wr_state_t                     wr_state;
    rd_state_t                     rd_state;
    logic [`JB_ID_W-1:0]           wr_id, rd_id;
    logic [31:0]                   wr_addr, rd_addr;
    logic [1:0]                    wr_burst, rd_burst;
    logic [`JB_LEN_W-1:0]          rd_len, rd_cnt;
    logic                          wr_err, rd_err; // sticky over the burst
    logic                          wr_beat_err, rd_beat_err, w_fire, wr_ok, r_fire;
    jtag_bridge_pkg::status_word_u stat_wr, stat_rd;

    // write channel
    assign aw_ready    = wr_state == WR_IDLE;
    assign wr_beat_err = wr_burst[1] || wr_addr < STAT_ADDR || wr_addr > CMD_ADDR ||
                         wr_addr == OUT_ADDR;
    assign w_ready     = wr_state == WR_DATA &&
                         (wr_beat_err || !((wr_addr == IN_ADDR && in_full) ||
                                           (wr_addr == CMD_ADDR && cmd_full)));
    assign w_fire      = w_valid && w_ready;
    assign wr_ok       = w_fire && !wr_beat_err; // error beats are dropped
    assign in_push     = wr_ok && wr_addr == IN_ADDR;
    assign cmd_push    = wr_ok && wr_addr == CMD_ADDR;
    assign push_data   = w.data;
    assign b_valid     = wr_state == WR_RESP;
    assign b.id        = wr_id;
    assign b.resp      = wr_err ? 2'b10 : 2'b00;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_state <= WR_IDLE;
            wr_err   <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: if (aw_valid) begin
                    wr_state <= WR_DATA;
                    wr_err   <= 1'b0;
                end
                WR_DATA: if (w_fire) begin
                    wr_err <= wr_err || wr_beat_err;
                    if (w.last) wr_state <= WR_RESP;
                end
                WR_RESP: if (b_ready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            wr_id    <= aw.id;
            wr_addr  <= aw.addr;
            wr_burst <= aw.burst;
        end else if (w_fire && wr_burst == 2'b01) begin
            wr_addr <= wr_addr + 32'd1;
        end
    end

    // status register, byte strobes on the raw view
    always_comb begin
        stat_wr.raw = '0;
        for (int i = 0; i < `JB_DATA_W / 8; i++) begin
            if (w.strb[i]) stat_wr.raw[8*i +: 8] = w.data[8*i +: 8];
        end
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            out_clear <= 1'b0;
            in_clear  <= 1'b0;
            cmd_clear <= 1'b0;
        end else begin
            out_clear <= wr_ok && wr_addr == STAT_ADDR && stat_wr.f.out_clear; // one cycle
            in_clear  <= wr_ok && wr_addr == STAT_ADDR && stat_wr.f.in_clear;
            cmd_clear <= wr_ok && wr_addr == STAT_ADDR && stat_wr.f.cmd_clear;
        end
    end

    always_comb begin
        stat_rd.raw         = '0;
        stat_rd.f.out_clear = out_clear;
        stat_rd.f.out_empty = out_empty;
        stat_rd.f.out_full  = out_full;
        stat_rd.f.in_clear  = in_clear;
        stat_rd.f.in_empty  = in_empty;
        stat_rd.f.in_full   = in_full;
        stat_rd.f.cmd_clear = cmd_clear;
        stat_rd.f.cmd_empty = cmd_empty;
        stat_rd.f.cmd_full  = cmd_full;
        stat_rd.f.cmd_done  = !shifter_busy && cmd_empty;
    end

    // read channel
    assign ar_ready    = rd_state == RD_IDLE;
    assign rd_beat_err = rd_burst[1] || rd_addr < STAT_ADDR || rd_addr > OUT_ADDR;
    assign r_valid     = rd_state == RD_DATA &&
                         (rd_beat_err || rd_addr == STAT_ADDR || !out_empty);
    assign r_fire      = r_valid && r_ready;
    assign out_pop     = r_fire && !rd_beat_err && rd_addr == OUT_ADDR;
    assign r.id        = rd_id;
    assign r.data      = rd_beat_err ? '1 : (rd_addr == STAT_ADDR ? stat_rd.raw : out_head);
    assign r.resp      = (rd_err || rd_beat_err) ? 2'b10 : 2'b00;
    assign r.last      = rd_cnt == rd_len;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
            rd_err   <= 1'b0;
        end else if (rd_state == RD_IDLE) begin
            rd_cnt <= '0;
            rd_err <= 1'b0;
            if (ar_valid) rd_state <= RD_DATA;
        end else if (r_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
            rd_err <= rd_err || rd_beat_err;
            if (r.last) rd_state <= RD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            rd_id    <= ar.id;
            rd_addr  <= ar.addr;
            rd_len   <= ar.len;
            rd_burst <= ar.burst;
        end else if (r_fire && rd_burst == 2'b01) begin
            rd_addr <= rd_addr + 32'd1;
        end
    end

    b_hold_a: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        b_valid && !b_ready |=> b_valid && $stable(b));
    w_ready_a: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        w_ready |-> wr_state == WR_DATA);

endmodule

`default_nettype wire

// ==== src/jtag_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "jtag_bridge_params.svh"

module jtag_bridge (
    input  wire                              clk,
    input  wire                              jtag_rstn_sync,
    input  wire jtag_bridge_pkg::bus_addr_t  aw,
    input  wire                              aw_valid,
    output logic                             aw_ready,
    input  wire jtag_bridge_pkg::bus_wdata_t w,
    input  wire                              w_valid,
    output logic                             w_ready,
    output jtag_bridge_pkg::bus_bresp_t      b,
    output logic                             b_valid,
    input  wire                              b_ready,
    input  wire jtag_bridge_pkg::bus_addr_t  ar,
    input  wire                              ar_valid,
    output logic                             ar_ready,
    output jtag_bridge_pkg::bus_rdata_t      r,
    output logic                             r_valid,
    input  wire                              r_ready,
    output logic                             tck,
    output logic                             tms,
    output logic                             tdi,
    input  wire                              tdo
);
    logic                      in_push, in_pop, in_clear, in_empty, in_full;
    logic                      cmd_push, cmd_pop, cmd_clear, cmd_empty, cmd_full;
    logic                      out_push, out_pop, out_clear, out_empty, out_full;
    logic [`JB_DATA_W-1:0]     push_data, in_head, out_data, out_head;
    jtag_bridge_pkg::cmd_word_u cmd_head;
    logic                      shifter_busy;

    jtag_bus_ctrl jtag_bus_ctrl_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .in_full(in_full), .in_empty(in_empty), .cmd_full(cmd_full), .cmd_empty(cmd_empty),
        .out_full(out_full), .out_empty(out_empty), .out_head(out_head),
        .shifter_busy(shifter_busy),
        .in_push(in_push), .cmd_push(cmd_push), .push_data(push_data), .out_pop(out_pop),
        .in_clear(in_clear), .cmd_clear(cmd_clear), .out_clear(out_clear)
    );

    sync_fifo #(.WIDTH(`JB_DATA_W)) in_fifo ( // host to tdi
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clear(in_clear),
        .push(in_push), .push_data(push_data), .pop(in_pop),
        .head(in_head), .empty(in_empty), .full(in_full)
    );

    sync_fifo #(.WIDTH(`JB_DATA_W)) cmd_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clear(cmd_clear),
        .push(cmd_push), .push_data(push_data), .pop(cmd_pop),
        .head(cmd_head), .empty(cmd_empty), .full(cmd_full)
    );

    sync_fifo #(.WIDTH(`JB_DATA_W)) out_fifo ( // tdo to host
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clear(out_clear),
        .push(out_push), .push_data(out_data), .pop(out_pop),
        .head(out_head), .empty(out_empty), .full(out_full)
    );

    tap_shifter tap_shifter_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .cmd_head(cmd_head), .cmd_empty(cmd_empty),
        .in_head(in_head), .in_empty(in_empty), .out_full(out_full), .tdo(tdo),
        .cmd_pop(cmd_pop), .in_pop(in_pop), .out_push(out_push), .out_data(out_data),
        .busy(shifter_busy), .tck(tck), .tms(tms), .tdi(tdi)
    );

endmodule

`default_nettype wire

// ==== verification/tb_jtag_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "jtag_bridge_params.svh"

module tb_jtag_bridge;
    localparam int          TIMEOUT = 2000;            // cycles per wait
    localparam logic [31:0] BASE    = `JB_OFFSET_ADDR;

    logic                        clk, jtag_rstn_sync;
    jtag_bridge_pkg::bus_addr_t  aw, ar;
    jtag_bridge_pkg::bus_wdata_t w;
    jtag_bridge_pkg::bus_bresp_t b;
    jtag_bridge_pkg::bus_rdata_t r;
    logic                        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic                        ar_valid, ar_ready, r_valid, r_ready;
    logic                        tck, tms, tdi;

    logic [31:0] rng = 32'h4bd1947c;
    int          checks = 0, errors = 0, timeouts = 0;
    int          pulse_cnt = 0, tms_cnt = 0, p0, t0;
    logic [31:0] wbuf [8];
    logic [3:0]  sbuf [8];
    logic [31:0] rdata [8];
    logic [1:0]  rresp [8];
    logic        rlast [8];
    logic [1:0]  bresp;
    logic [31:0] words [3];
    logic [31:0] stat;

    jtag_bridge jtag_bridge_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .tck(tck), .tms(tms), .tdi(tdi),
        .tdo(tdi) // loopback
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (tck) begin // tck high lasts one clk per pulse
            pulse_cnt <= pulse_cnt + 1;
            tms_cnt   <= tms_cnt + (tms ? 1 : 0);
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng = x;
        return x;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("ERROR: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic bus_write(input logic [3:0] tid, input logic [31:0] addr,
                             input logic [1:0] burst, input int n);
        int cnt;
        @(posedge clk);
        aw       <= '{id: tid, addr: addr, len: `JB_LEN_W'(n - 1), burst: burst};
        aw_valid <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!aw_ready && cnt < TIMEOUT);
        if (!aw_ready) note_timeout("write address handshake");
        aw_valid <= 1'b0;
        for (int i = 0; i < n; i++) begin
            w       <= '{data: wbuf[i], strb: sbuf[i], last: i == n - 1};
            w_valid <= 1'b1;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
            end while (!w_ready && cnt < TIMEOUT);
            if (!w_ready) note_timeout("write data beat");
        end
        w_valid <= 1'b0;
        b_ready <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!b_valid && cnt < TIMEOUT);
        if (!b_valid) note_timeout("write response");
        check_val("b.id", 32'(tid), 32'(b.id));
        bresp = b.resp;
        b_ready <= 1'b0;
    endtask

    task automatic write_word(input logic [3:0] tid, input logic [31:0] addr,
                              input logic [31:0] data);
        wbuf[0] = data;
        sbuf[0] = 4'hf;
        bus_write(tid, addr, 2'd0, 1);
    endtask

    task automatic bus_read(input logic [3:0] tid, input logic [31:0] addr,
                            input logic [1:0] burst, input int n);
        int cnt;
        @(posedge clk);
        ar       <= '{id: tid, addr: addr, len: `JB_LEN_W'(n - 1), burst: burst};
        ar_valid <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!ar_ready && cnt < TIMEOUT);
        if (!ar_ready) note_timeout("read address handshake");
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
        for (int i = 0; i < n; i++) begin
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
            end while (!r_valid && cnt < TIMEOUT);
            if (!r_valid) note_timeout("read data beat");
            check_val("r.id", 32'(tid), 32'(r.id));
            rdata[i] = r.data;
            rresp[i] = r.resp;
            rlast[i] = r.last;
        end
        r_ready <= 1'b0;
    endtask

    task automatic read_status();
        bus_read(4'd0, BASE, 2'd0, 1);
        check_val("status resp", 32'd0, 32'(rresp[0]));
        stat = rdata[0];
    endtask

    task automatic wait_cmd_done();
        int tries;
        tries = 0;
        do begin
            read_status();
            tries++;
        end while (!stat[24] && tries < 200);
        if (!stat[24]) note_timeout("cmd_done");
    endtask

    initial begin
        jtag_rstn_sync <= 1'b0;
        aw       <= '0;
        aw_valid <= 1'b0;
        w        <= '0;
        w_valid  <= 1'b0;
        b_ready  <= 1'b0;
        ar       <= '0;
        ar_valid <= 1'b0;
        r_ready  <= 1'b0;
        repeat (5) @(posedge clk);
        jtag_rstn_sync <= 1'b1;
        @(posedge clk);

        // reset state
        check_val("reset aw_ready", 32'd1, 32'(aw_ready));
        check_val("reset ar_ready", 32'd1, 32'(ar_ready));
        check_val("reset b_valid", 32'd0, 32'(b_valid));
        check_val("reset r_valid", 32'd0, 32'(r_valid));
        check_val("reset w_ready", 32'd0, 32'(w_ready));
        check_val("reset tck", 32'd0, 32'(tck));
        check_val("reset tms", 32'd0, 32'(tms));
        check_val("reset tdi", 32'd0, 32'(tdi));
        read_status();
        check_val("reset status", 32'h0102_0202, stat); // all empty, cmd_done

        // illegal accesses
        write_word(4'd1, BASE + 32'd1, 32'h0);
        check_val("write shift-out resp", 32'd2, 32'(bresp));
        write_word(4'd2, BASE + 32'd4, 32'h0);
        check_val("write out of range resp", 32'd2, 32'(bresp));
        wbuf[0] = 32'h0;
        sbuf[0] = 4'h0;
        bus_write(4'd3, BASE, 2'd2, 1);
        check_val("write burst 2 resp", 32'd2, 32'(bresp));
        bus_read(4'd4, BASE + 32'd2, 2'd0, 1);
        check_val("read shift-in data", 32'hffff_ffff, rdata[0]);
        check_val("read shift-in resp", 32'd2, 32'(rresp[0]));
        write_word(4'd5, BASE, 32'h0);
        check_val("legal status write resp", 32'd0, 32'(bresp));

        // three full words through the loopback
        for (int i = 0; i < 3; i++) begin
            words[i] = next_random();
            wbuf[i]  = words[i];
            sbuf[i]  = 4'hf;
        end
        bus_write(4'd6, BASE + 32'd2, 2'd0, 3);
        check_val("shift-in burst resp", 32'd0, 32'(bresp));
        write_word(4'd7, BASE + 32'd3, {`JB_OP_SHIFT, 28'd96});
        check_val("shift cmd resp", 32'd0, 32'(bresp));
        wait_cmd_done();
        bus_read(4'd8, BASE + 32'd1, 2'd0, 3);
        for (int i = 0; i < 3; i++) begin
            check_val("loopback word", words[i], rdata[i]);
            check_val("loopback resp", 32'd0, 32'(rresp[i]));
            check_val("loopback last", 32'(i == 2), 32'(rlast[i]));
        end
        read_status();
        check_val("out empty after read", 32'd1, 32'(stat[1]));

        // 12 bits, zero filled above
        words[0] = next_random();
        write_word(4'd9, BASE + 32'd2, words[0]);
        write_word(4'd10, BASE + 32'd3, {`JB_OP_SHIFT, 28'd12});
        wait_cmd_done();
        bus_read(4'd11, BASE + 32'd1, 2'd0, 1);
        check_val("partial word", words[0] & 32'h0000_0fff, rdata[0]);
        check_val("partial last", 32'd1, 32'(rlast[0]));

        // TMS and IDLE pulses
        p0 = pulse_cnt;
        t0 = tms_cnt;
        write_word(4'd12, BASE + 32'd3, {`JB_OP_TMS, 28'd5});
        wait_cmd_done();
        check_val("tms pulses", 32'd5, 32'(pulse_cnt - p0));
        check_val("tms high pulses", 32'd5, 32'(tms_cnt - t0));
        p0 = pulse_cnt;
        t0 = tms_cnt;
        write_word(4'd13, BASE + 32'd3, {`JB_OP_IDLE, 28'd3});
        wait_cmd_done();
        check_val("idle pulses", 32'd3, 32'(pulse_cnt - p0));
        check_val("idle tms high pulses", 32'd0, 32'(tms_cnt - t0));
        read_status();
        check_val("out empty after tms/idle", 32'd1, 32'(stat[1]));

        // in FIFO clear through an incrementing burst
        wbuf[0] = next_random();
        wbuf[1] = next_random();
        sbuf[0] = 4'hf;
        sbuf[1] = 4'hf;
        bus_write(4'd14, BASE + 32'd2, 2'd0, 2);
        check_val("fill in fifo resp", 32'd0, 32'(bresp));
        read_status();
        check_val("in empty before clear", 32'd0, 32'(stat[9]));
        wbuf[0] = 32'h0000_0100; // in_clear
        sbuf[0] = 4'b0010;
        wbuf[1] = 32'h0;
        sbuf[1] = 4'hf;
        bus_write(4'd15, BASE, 2'd1, 2); // second beat hits the shift-out port
        check_val("incr burst resp", 32'd2, 32'(bresp));
        read_status();
        check_val("in empty after clear", 32'd1, 32'(stat[9]));
        check_val("in clear self clears", 32'd0, 32'(stat[8]));

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== jtag_bridge.f ====
+incdir+src
src/jtag_bridge_pkg.sv
src/sync_fifo.sv
src/tap_shifter.sv
src/jtag_bus_ctrl.sv
src/jtag_bridge.sv
verification/tb_jtag_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_jtag_bridge \
    -f jtag_bridge.f -o tb_jtag_bridge > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_jtag_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
